// ==== gpio_pkg.sv ====
package gpio_pkg;

   // ------------------------------------------------------------------
   // bus geometry
   // ------------------------------------------------------------------
   localparam int APB_DW   = 32;
   localparam int APB_AW   = 8;
   localparam int MAX_PINS = 32;
   localparam int IDX_W    = $clog2(MAX_PINS);

   // register map, everything below ADDR_INT is per-pin config
   localparam logic [APB_AW-1:0] ADDR_INT   = 8'h80;
   localparam logic [APB_AW-1:0] ADDR_GPIN  = 8'h90;
   localparam logic [APB_AW-1:0] ADDR_GPOUT = 8'hA0;

   // interrupt source select, codes 5..7 disable the pin interrupt
   typedef enum logic [2:0] {
      INT_LEVEL_HIGH = 3'd0,
      INT_LEVEL_LOW  = 3'd1,
      INT_EDGE_POS   = 3'd2,
      INT_EDGE_NEG   = 3'd3,
      INT_EDGE_BOTH  = 3'd4
   } int_type_e;

   // per-pin config byte, msb first
   typedef struct packed {
      int_type_e int_type;
      logic      spare;
      logic      int_en;
      logic      oe_en;
      logic      in_en;
      logic      out_en;
   } pin_cfg_t;

   // apb request as seen by the register interface
   typedef struct packed {
      logic              sel;
      logic              enable;
      logic              write;
      logic [APB_AW-1:0] addr;
      logic [APB_DW-1:0] wdata;
   } apb_req_t;

   // decoded write strobes plus the write data
   typedef struct packed {
      logic              cfg_we;
      logic [IDX_W-1:0]  cfg_idx;
      logic              int_clr;
      logic              gpout_we;
      logic [APB_DW-1:0] wdata;
   } wr_strobe_t;

endpackage

// ==== gpio_apb_regif.sv ====
`timescale 1ns/1ps

module gpio_apb_regif
   import gpio_pkg::*;
#(
   parameter int IO_NUM = 32
)
(
   input  apb_req_t              req_i,
   input  pin_cfg_t [IO_NUM-1:0] cfg_i,
   input  logic [IO_NUM-1:0]     pin_cur_i,
   input  logic [IO_NUM-1:0]     int_status_i,
   input  logic [IO_NUM-1:0]     gpout_i,
   output wr_strobe_t            strobe_o,
   output logic [APB_DW-1:0]     rdata_o
);

   logic              wr_qual;
   logic              cfg_space;
   logic [IDX_W-1:0]  pin_idx;
   logic              idx_valid;
   logic [IO_NUM-1:0] in_mask;

   // ------------------------------------------------------------------
   // address decode
   // ------------------------------------------------------------------
   assign wr_qual   = req_i.sel & req_i.enable & req_i.write;
   assign cfg_space = (req_i.addr < ADDR_INT);
   assign pin_idx   = req_i.addr[IDX_W+1:2];
   // pins beyond IO_NUM have no register
   assign idx_valid = (int'(pin_idx) < IO_NUM);

   assign strobe_o.cfg_we   = wr_qual & cfg_space & idx_valid;
   assign strobe_o.cfg_idx  = pin_idx;
   assign strobe_o.int_clr  = wr_qual & (req_i.addr == ADDR_INT);
   assign strobe_o.gpout_we = wr_qual & (req_i.addr == ADDR_GPOUT);
   assign strobe_o.wdata    = req_i.wdata;

   always_comb
   begin
      for (int i = 0; i < IO_NUM; i++)
      begin
         in_mask[i] = cfg_i[i].in_en;
      end
   end

   // ------------------------------------------------------------------
   // read mux, purely combinational from the address
   // ------------------------------------------------------------------
   always_comb
   begin
      rdata_o = '0;
      if (cfg_space)
      begin
         if (idx_valid)
         begin
            rdata_o[7:0] = cfg_i[pin_idx];
         end
      end
      else
      begin
         case (req_i.addr)
            ADDR_INT:   rdata_o[IO_NUM-1:0] = int_status_i;
            ADDR_GPIN:  rdata_o[IO_NUM-1:0] = pin_cur_i & in_mask;
            ADDR_GPOUT: rdata_o[IO_NUM-1:0] = gpout_i;
            default:    rdata_o = '0;
         endcase
      end
   end

endmodule

// ==== gpio_config_bank.sv ====
`timescale 1ns/1ps

module gpio_config_bank
   import gpio_pkg::*;
#(
   parameter int IO_NUM = 32
)
(
   input  logic                  PCLK,
   input  logic                  aresetn,
   input  wr_strobe_t            strobe_i,
   output pin_cfg_t [IO_NUM-1:0] cfg_o
);

   pin_cfg_t [IO_NUM-1:0] cfg_q;

   // one byte per pin, loaded from the low data byte
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         cfg_q <= '0;
      end
      else
      begin
         for (int i = 0; i < IO_NUM; i++)
         begin
            if (strobe_i.cfg_we && (int'(strobe_i.cfg_idx) == i))
            begin
               cfg_q[i] <= pin_cfg_t'(strobe_i.wdata[7:0]);
            end
         end
      end
   end

   assign cfg_o = cfg_q;

endmodule

// ==== gpio_input_sync.sv ====
`timescale 1ns/1ps

module gpio_input_sync
#(
   parameter int IO_NUM = 32
)
(
   input  logic              PCLK,
   input  logic              aresetn,
   input  logic [IO_NUM-1:0] gpio_in_i,
   output logic [IO_NUM-1:0] pin_cur_o,
   output logic [IO_NUM-1:0] pin_prev_o
);

   logic [IO_NUM-1:0] stage1;
   logic [IO_NUM-1:0] stage2;
   logic [IO_NUM-1:0] stage3;

   // two flops for metastability, third gives the older sample
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         stage1 <= '0;
         stage2 <= '0;
         stage3 <= '0;
      end
      else
      begin
         stage1 <= gpio_in_i;
         stage2 <= stage1;
         stage3 <= stage2;
      end
   end

   assign pin_prev_o = stage2;
   assign pin_cur_o  = stage3;

endmodule

// ==== gpio_irq_detect.sv ====
`timescale 1ns/1ps

module gpio_irq_detect
   import gpio_pkg::*;
#(
   parameter int IO_NUM = 32
)
(
   input  logic                  PCLK,
   input  logic                  aresetn,
   input  pin_cfg_t [IO_NUM-1:0] cfg_i,
   input  logic [IO_NUM-1:0]     pin_cur_i,
   input  logic [IO_NUM-1:0]     pin_prev_i,
   input  wr_strobe_t            strobe_i,
   output logic [IO_NUM-1:0]     int_o,
   output logic                  int_or_o,
   output logic [IO_NUM-1:0]     int_status_o
);

   logic [IO_NUM-1:0] int_en;
   logic [IO_NUM-1:0] int_sel;
   logic [IO_NUM-1:0] clr_mask;
   logic [IO_NUM-1:0] pos_set;
   logic [IO_NUM-1:0] neg_set;
   logic [IO_NUM-1:0] edge_pos;
   logic [IO_NUM-1:0] edge_neg;
   logic [IO_NUM-1:0] edge_both;

   // set wins over a clear on the same edge, int_en low holds at zero
   function automatic logic [IO_NUM-1:0] latch_next(
      input logic [IO_NUM-1:0] q,
      input logic [IO_NUM-1:0] set
   );
      return int_en & (set | (q & ~clr_mask));
   endfunction

   // ------------------------------------------------------------------
   // edge detection, prev is the newer sample
   // ------------------------------------------------------------------
   assign pos_set  = pin_prev_i & ~pin_cur_i;
   assign neg_set  = ~pin_prev_i & pin_cur_i;
   assign clr_mask = strobe_i.int_clr ? strobe_i.wdata[IO_NUM-1:0] : '0;

   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         edge_pos  <= '0;
         edge_neg  <= '0;
         edge_both <= '0;
      end
      else
      begin
         edge_pos  <= latch_next(edge_pos, pos_set);
         edge_neg  <= latch_next(edge_neg, neg_set);
         edge_both <= latch_next(edge_both, pos_set | neg_set);
      end
   end

   // ------------------------------------------------------------------
   // source select per pin
   // ------------------------------------------------------------------
   always_comb
   begin
      for (int i = 0; i < IO_NUM; i++)
      begin
         int_en[i] = cfg_i[i].int_en;
         case (cfg_i[i].int_type)
            INT_LEVEL_HIGH: int_sel[i] = pin_cur_i[i];
            INT_LEVEL_LOW:  int_sel[i] = ~pin_cur_i[i];
            INT_EDGE_POS:   int_sel[i] = edge_pos[i];
            INT_EDGE_NEG:   int_sel[i] = edge_neg[i];
            INT_EDGE_BOTH:  int_sel[i] = edge_both[i];
            default:        int_sel[i] = 1'b0;
         endcase
      end
   end

   assign int_o    = int_sel & int_en;
   assign int_or_o = |int_o;

   // status tracks int_o except while software clears bits
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         int_status_o <= '0;
      end
      else if (strobe_i.int_clr)
      begin
         int_status_o <= int_status_o & ~clr_mask;
      end
      else
      begin
         int_status_o <= int_o;
      end
   end

endmodule

// ==== gpio_output_ctrl.sv ====
`timescale 1ns/1ps

module gpio_output_ctrl
   import gpio_pkg::*;
#(
   parameter int                IO_NUM      = 32,
   parameter logic [APB_DW-1:0] GPOUT_RESET = '0
)
(
   input  logic                  PCLK,
   input  logic                  aresetn,
   input  wr_strobe_t            strobe_i,
   input  pin_cfg_t [IO_NUM-1:0] cfg_i,
   output logic [IO_NUM-1:0]     gpout_o,
   output logic [IO_NUM-1:0]     gpio_out_o,
   output logic [IO_NUM-1:0]     gpio_oe_o
);

   logic [IO_NUM-1:0] out_en;
   logic [IO_NUM-1:0] oe_en;

   // data-out word
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         gpout_o <= GPOUT_RESET[IO_NUM-1:0];
      end
      else if (strobe_i.gpout_we)
      begin
         gpout_o <= strobe_i.wdata[IO_NUM-1:0];
      end
   end

   always_comb
   begin
      for (int i = 0; i < IO_NUM; i++)
      begin
         out_en[i] = cfg_i[i].out_en;
         oe_en[i]  = cfg_i[i].oe_en;
      end
   end

   // oe only meaningful on pins configured as outputs
   assign gpio_out_o = gpout_o & out_en;
   assign gpio_oe_o  = oe_en & out_en;

endmodule

// ==== gpio_top.sv ====
`timescale 1ns/1ps

module gpio_top
   import gpio_pkg::*;
#(
   parameter int                IO_NUM      = 32,
   parameter logic [APB_DW-1:0] GPOUT_RESET = '0
)
(
   input  logic              PCLK,
   input  logic              aresetn,
   input  logic              psel_i,
   input  logic              penable_i,
   input  logic              pwrite_i,
   input  logic [APB_AW-1:0] paddr_i,
   input  logic [APB_DW-1:0] pwdata_i,
   output logic [APB_DW-1:0] prdata_o,
   output logic              pready_o,
   output logic              pslverr_o,
   input  logic [IO_NUM-1:0] gpio_in_i,
   output logic [IO_NUM-1:0] gpio_out_o,
   output logic [IO_NUM-1:0] gpio_oe_o,
   output logic [IO_NUM-1:0] int_o,
   output logic              int_or_o
);

   apb_req_t              req;
   wr_strobe_t            strobe;
   pin_cfg_t [IO_NUM-1:0] cfg;
   logic [IO_NUM-1:0]     pin_cur;
   logic [IO_NUM-1:0]     pin_prev;
   logic [IO_NUM-1:0]     int_status;
   logic [IO_NUM-1:0]     gpout;

   // ------------------------------------------------------------------
   // apb side, zero wait states and no errors
   // ------------------------------------------------------------------
   assign req.sel    = psel_i;
   assign req.enable = penable_i;
   assign req.write  = pwrite_i;
   assign req.addr   = paddr_i;
   assign req.wdata  = pwdata_i;

   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   gpio_apb_regif #(.IO_NUM(IO_NUM)) u_regif (
      .req_i        (req),
      .cfg_i        (cfg),
      .pin_cur_i    (pin_cur),
      .int_status_i (int_status),
      .gpout_i      (gpout),
      .strobe_o     (strobe),
      .rdata_o      (prdata_o)
   );

   gpio_config_bank #(.IO_NUM(IO_NUM)) u_config_bank (
      .PCLK     (PCLK),
      .aresetn  (aresetn),
      .strobe_i (strobe),
      .cfg_o    (cfg)
   );

   gpio_input_sync #(.IO_NUM(IO_NUM)) u_input_sync (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .gpio_in_i  (gpio_in_i),
      .pin_cur_o  (pin_cur),
      .pin_prev_o (pin_prev)
   );

   gpio_irq_detect #(.IO_NUM(IO_NUM)) u_irq_detect (
      .PCLK         (PCLK),
      .aresetn      (aresetn),
      .cfg_i        (cfg),
      .pin_cur_i    (pin_cur),
      .pin_prev_i   (pin_prev),
      .strobe_i     (strobe),
      .int_o        (int_o),
      .int_or_o     (int_or_o),
      .int_status_o (int_status)
   );

   gpio_output_ctrl #(
      .IO_NUM      (IO_NUM),
      .GPOUT_RESET (GPOUT_RESET)
   ) u_output_ctrl (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .strobe_i   (strobe),
      .cfg_i      (cfg),
      .gpout_o    (gpout),
      .gpio_out_o (gpio_out_o),
      .gpio_oe_o  (gpio_oe_o)
   );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
   output logic clk_o,
   output logic rstn_o
);

   // 8 ns period
   initial
   begin
      clk_o = 1'b0;
      forever #4 clk_o = ~clk_o;
   end

   // reset held low for 10 cycles
   initial
   begin
      rstn_o = 1'b0;
      repeat (10) @(posedge clk_o);
      rstn_o <= 1'b1;
   end

endmodule

// ==== tb_gpio_top.sv ====
`timescale 1ns/1ps

module tb_gpio_top;
   import gpio_pkg::*;

   localparam int          IO_NUM      = 32;
   localparam logic [31:0] GPOUT_RESET = 32'h5A3C_0F81;
   localparam int          WAIT_LIMIT  = 20;

   logic        clk;
   logic        rstn;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic [31:0] gpio_in;
   logic [31:0] gpio_out;
   logic [31:0] gpio_oe;
   logic [31:0] int_o;
   logic        int_or_o;

   integer      seed;
   int          mismatches;
   int          failures;

   // reference model state
   logic [7:0]  m_cfg [0:IO_NUM-1];
   logic [31:0] m_gpout;
   logic [31:0] m_s1;
   logic [31:0] m_s2;
   logic [31:0] m_s3;
   logic [31:0] m_pos;
   logic [31:0] m_neg;
   logic [31:0] m_both;
   logic [31:0] m_status;

   tb_clock_gen u_clock_gen (
      .clk_o  (clk),
      .rstn_o (rstn)
   );

   gpio_top #(
      .IO_NUM      (IO_NUM),
      .GPOUT_RESET (GPOUT_RESET)
   ) u_gpio_top (
      .PCLK       (clk),
      .aresetn    (rstn),
      .psel_i     (psel),
      .penable_i  (penable),
      .pwrite_i   (pwrite),
      .paddr_i    (paddr),
      .pwdata_i   (pwdata),
      .prdata_o   (prdata),
      .pready_o   (pready),
      .pslverr_o  (pslverr),
      .gpio_in_i  (gpio_in),
      .gpio_out_o (gpio_out),
      .gpio_oe_o  (gpio_oe),
      .int_o      (int_o),
      .int_or_o   (int_or_o)
   );

   // ------------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------------
   function automatic logic [31:0] cfg_bits(input int pos);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < IO_NUM; i++)
      begin
         r[i] = m_cfg[i][pos];
      end
      return r;
   endfunction

   function automatic logic [31:0] model_int();
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < IO_NUM; i++)
      begin
         if (m_cfg[i][3])
         begin
            case (m_cfg[i][7:5])
               3'd0:    r[i] = m_s3[i];
               3'd1:    r[i] = ~m_s3[i];
               3'd2:    r[i] = m_pos[i];
               3'd3:    r[i] = m_neg[i];
               3'd4:    r[i] = m_both[i];
               default: r[i] = 1'b0;
            endcase
         end
      end
      return r;
   endfunction

   function automatic logic [31:0] model_read(input logic [7:0] addr);
      if (addr < ADDR_INT)
         return {24'h0, m_cfg[addr[6:2]]};
      case (addr)
         ADDR_INT:   return m_status;
         ADDR_GPIN:  return m_s3 & cfg_bits(1);
         ADDR_GPOUT: return m_gpout;
         default:    return 32'h0;
      endcase
   endfunction

   always @(posedge clk or negedge rstn)
   begin : model_update
      logic        wr;
      logic [31:0] clr;
      logic [31:0] en;
      logic [31:0] pset;
      logic [31:0] nset;
      if (!rstn)
      begin
         for (int i = 0; i < IO_NUM; i++)
         begin
            m_cfg[i] <= 8'h00;
         end
         m_gpout  <= GPOUT_RESET;
         m_s1     <= '0;
         m_s2     <= '0;
         m_s3     <= '0;
         m_pos    <= '0;
         m_neg    <= '0;
         m_both   <= '0;
         m_status <= '0;
      end
      else
      begin
         wr   = psel & penable & pwrite;
         clr  = (wr && paddr == ADDR_INT) ? pwdata : 32'h0;
         en   = cfg_bits(3);
         // s2 holds the newer sample and s3 the older one
         pset = m_s2 & ~m_s3;
         nset = ~m_s2 & m_s3;
         m_s1   <= gpio_in;
         m_s2   <= m_s1;
         m_s3   <= m_s2;
         m_pos  <= en & (pset | (m_pos & ~clr));
         m_neg  <= en & (nset | (m_neg & ~clr));
         m_both <= en & (pset | nset | (m_both & ~clr));
         if (wr && paddr == ADDR_INT)
            m_status <= m_status & ~clr;
         else
            m_status <= model_int();
         if (wr && paddr < ADDR_INT)
            m_cfg[paddr[6:2]] <= pwdata[7:0];
         if (wr && paddr == ADDR_GPOUT)
            m_gpout <= pwdata;
      end
   end

   // ------------------------------------------------------------------
   // checks and bus tasks
   // ------------------------------------------------------------------
   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      mismatches++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
   endtask

   task automatic report_failure(input string what);
      failures++;
      $display("Error at %0t: %s", $time, what);
   endtask

   // outputs compared on every falling edge
   always @(negedge clk)
   begin : output_check
      logic [31:0] exp_int;
      if (rstn)
      begin
         exp_int = model_int();
         if (int_o !== exp_int)
            report_mismatch("int_o", int_o, exp_int);
         if (int_or_o !== (|exp_int))
            report_mismatch("int_or_o", {31'h0, int_or_o}, {31'h0, |exp_int});
         if (gpio_out !== (m_gpout & cfg_bits(0)))
            report_mismatch("gpio_out_o", gpio_out, m_gpout & cfg_bits(0));
         if (gpio_oe !== (cfg_bits(2) & cfg_bits(0)))
            report_mismatch("gpio_oe_o", gpio_oe, cfg_bits(2) & cfg_bits(0));
         if (pready !== 1'b1)
            report_mismatch("pready_o", {31'h0, pready}, 32'h1);
         if (pslverr !== 1'b0)
            report_mismatch("pslverr_o", {31'h0, pslverr}, 32'h0);
      end
   end

   task automatic wait_ready();
      int n;
      n = 0;
      @(negedge clk);
      while (pready !== 1'b1 && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (pready !== 1'b1)
         report_failure("no pready_o in the access phase");
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      wait_ready();
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      // read path shows the written register in the cycle after the write
      @(negedge clk);
      if (prdata !== model_read(addr))
         report_mismatch("prdata_o", prdata, model_read(addr));
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      logic [31:0] exp;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      wait_ready();
      data = prdata;
      exp  = model_read(addr);
      if (data !== exp)
         report_mismatch("prdata_o", data, exp);
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic wait_int(input int pin, input logic level);
      int n;
      n = 0;
      @(negedge clk);
      while (int_o[pin] !== level && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (int_o[pin] !== level)
         report_failure($sformatf("int_o[%0d] never reached %b", pin, level));
   endtask

   // ------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------
   initial
   begin : main_seq
      logic [31:0] data;
      logic [31:0] word;
      logic [7:0]  addr;
      logic [2:0]  types [0:5];
      int          idx;
      int          n;
      types = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd7};
      seed       = 21;
      mismatches = 0;
      failures   = 0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = 8'h00;
      pwdata     = 32'h0;
      gpio_in    = 32'h0;

      n = 0;
      while (rstn !== 1'b1 && n < 50)
      begin
         @(posedge clk);
         n++;
      end
      if (rstn !== 1'b1)
         report_failure("reset was never released");

      // reset values
      @(negedge clk);
      if (int_o !== 32'h0)
         report_mismatch("int_o", int_o, 32'h0);
      if (int_or_o !== 1'b0)
         report_mismatch("int_or_o", {31'h0, int_or_o}, 32'h0);
      if (gpio_out !== 32'h0)
         report_mismatch("gpio_out_o", gpio_out, 32'h0);
      if (gpio_oe !== 32'h0)
         report_mismatch("gpio_oe_o", gpio_oe, 32'h0);
      for (int i = 0; i < IO_NUM; i++)
      begin
         apb_read({i[5:0], 2'b00}, data);
         if (data !== 32'h0)
            report_mismatch("prdata_o", data, 32'h0);
      end
      apb_read(ADDR_GPOUT, data);
      if (data !== GPOUT_RESET)
         report_mismatch("prdata_o", data, GPOUT_RESET);

      // config read back of the low byte
      repeat (24)
      begin
         idx  = $random(seed) & 31;
         word = $random(seed);
         addr = {idx[5:0], 2'b00};
         apb_write(addr, word);
         apb_read(addr, data);
         if (data !== {24'h0, word[7:0]})
            report_mismatch("prdata_o", data, {24'h0, word[7:0]});
      end
      // addresses with no register read as zero
      for (int i = 0; i < 6; i++)
      begin
         apb_read(8'h84 + 8'(i * 8), data);
         if (data !== 32'h0)
            report_mismatch("prdata_o", data, 32'h0);
      end

      // data-out word
      repeat (10)
      begin
         word = $random(seed);
         apb_write(ADDR_GPOUT, word);
         apb_read(ADDR_GPOUT, data);
         if (data !== word)
            report_mismatch("prdata_o", data, word);
      end

      // input word held long enough to pass the synchronizer
      repeat (10)
      begin
         word = $random(seed);
         @(posedge clk);
         gpio_in <= word;
         repeat (5) @(posedge clk);
         apb_read(ADDR_GPIN, data);
         if (data !== (word & cfg_bits(1)))
            report_mismatch("prdata_o", data, word & cfg_bits(1));
      end

      // one pin per interrupt type with int_en and in_en set
      @(posedge clk);
      gpio_in <= 32'h0;
      repeat (5) @(posedge clk);
      for (int i = 0; i < 6; i++)
      begin
         apb_write({i[5:0], 2'b00}, {24'h0, types[i], 5'b01010});
      end
      apb_write(ADDR_INT, 32'hFFFF_FFFF);
      @(posedge clk);
      gpio_in <= 32'h0000_003F;
      wait_int(0, 1'b1);
      wait_int(2, 1'b1);
      wait_int(4, 1'b1);
      @(posedge clk);
      gpio_in <= 32'h0;
      wait_int(0, 1'b0);
      wait_int(3, 1'b1);
      if (int_o[2] !== 1'b1)
         report_mismatch("int_o[2]", {31'h0, int_o[2]}, 32'h1);
      apb_read(ADDR_INT, data);
      apb_write(ADDR_INT, 32'h0000_0014);
      if (int_o[2] !== 1'b0)
         report_mismatch("int_o[2]", {31'h0, int_o[2]}, 32'h0);
      if (int_o[3] !== 1'b1)
         report_mismatch("int_o[3]", {31'h0, int_o[3]}, 32'h1);
      apb_read(ADDR_INT, data);

      // int_en low drops a pending level interrupt
      @(posedge clk);
      gpio_in <= 32'h0000_0001;
      wait_int(0, 1'b1);
      apb_write(8'h00, 32'h0000_0002);
      if (int_o[0] !== 1'b0)
         report_mismatch("int_o[0]", {31'h0, int_o[0]}, 32'h0);

      // random pin activity against the model
      repeat (40)
      begin
         @(posedge clk);
         gpio_in <= $random(seed);
      end
      apb_read(ADDR_INT, data);
      apb_write(ADDR_INT, $random(seed));
      apb_read(ADDR_INT, data);

      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

   // overall limit on run time
   initial
   begin
      #100000;
      report_failure("simulation did not finish within the time limit");
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== project.f ====
gpio_pkg.sv
gpio_apb_regif.sv
gpio_config_bank.sv
gpio_input_sync.sv
gpio_irq_detect.sv
gpio_output_ctrl.sv
gpio_top.sv
tb_clock_gen.sv
tb_gpio_top.sv
